//--- addrgen_ctrl.sv
// Address generator control FSM
// Accepts a request, checks base alignment, waits out pending scalar
// stores and sequences the AX transfers until the request completes

`timescale 1ns/1ps
`default_nettype none

module addrgen_ctrl (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  // Request from the sequencer
  input  wire addrgen_pkg::vmem_req_t req_i,
  input  wire logic                   req_valid_i,
  // Scalar store still in flight in the core
  input  wire logic                   core_st_pending_i,
  // Datapath status
  input  wire logic                   last_i,
  input  wire logic                   issue_ok_i,
  input  wire logic                   ax_done_i,
  // Datapath control
  output logic                        load_o,
  output logic                        step_o,
  output logic                        issue_o,
  output logic                        is_load_o,
  output logic                        is_burst_o,
  output addrgen_pkg::vew_e           vew_o,
  // Completion toward the sequencer
  output logic                        ack_o,
  output logic                        exc_o
);

  import addrgen_pkg::*;

  ctrl_state_e state_q, state_d;

  // Request attributes kept for the whole request
  logic is_load_q;
  logic is_burst_q;
  vew_e vew_q;

  // Alignment check of the base address against the element width
  logic [BUS_SIZE:0]   ew_bytes;
  logic [BUS_SIZE-1:0] ew_mask;
  logic                addr_misaligned;

  // One AX handshake completed on the selected channel
  logic xfer;

  assign ew_bytes        = (BUS_SIZE + 1)'(1) << vew_q;
  assign ew_mask         = BUS_SIZE'(ew_bytes - 1'b1);
  // Source holds the request until ack, so the base is still valid here
  assign addr_misaligned = |(req_i.addr[BUS_SIZE-1:0] & ew_mask);

  assign xfer = issue_ok_i && ax_done_i;

  //////////////////////////////////////////////////////////////////////
  // Next state and strobes
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    load_o  = 1'b0;
    step_o  = 1'b0;
    issue_o = 1'b0;
    ack_o   = 1'b0;
    exc_o   = 1'b0;

    case (state_q)
      IDLE: begin
        // Capture the request into the datapath
        if (req_valid_i) begin
          load_o  = 1'b1;
          state_d = CHECK;
        end
      end
      CHECK: begin
        if (addr_misaligned) begin
          // Nothing goes out on AR/AW, only the exception
          ack_o   = 1'b1;
          exc_o   = 1'b1;
          state_d = IDLE;
        end else if (core_st_pending_i) begin
          state_d = WAITING;
        end else begin
          state_d = REQUESTING;
        end
      end
      WAITING: begin
        // Hold off until the core store drains
        if (!core_st_pending_i) begin
          state_d = REQUESTING;
        end
      end
      REQUESTING: begin
        issue_o = 1'b1;
        if (xfer) begin
          step_o = 1'b1;
          // Burst is a single transfer, strided ends on the last element
          if (is_burst_q || last_i) begin
            ack_o   = 1'b1;
            state_d = IDLE;
          end
        end
      end
      default: state_d = IDLE;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // State and request attributes
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      is_load_q  <= 1'b0;
      is_burst_q <= 1'b0;
      vew_q      <= EW8;
    end else begin
      state_q <= state_d;
      if (load_o) begin
        is_load_q  <= req_i.is_load;
        is_burst_q <= req_i.is_burst;
        vew_q      <= req_i.vew;
      end
    end
  end

  assign is_load_o  = is_load_q;
  assign is_burst_o = is_burst_q;
  assign vew_o      = vew_q;

endmodule

`default_nettype wire

//--- addrgen_pkg.sv
// Vector memory address generator, shared definitions
// Widths, request and channel payload types, and FSM encodings

`default_nettype none

package addrgen_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////////////////////////

  // Byte address width
  localparam int unsigned ADDR_W      = 32;
  // Data bus is 64 bits wide
  localparam int unsigned BUS_BYTES   = 8;
  localparam int unsigned BUS_SIZE    = 3;
  // Element count width
  localparam int unsigned VL_W        = 16;
  // Load/store unit request queue
  localparam int unsigned QUEUE_DEPTH = 4;
  localparam int unsigned QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
  localparam int unsigned QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [VL_W-1:0]   vlen_t;
  typedef logic [31:0]       stride_t;
  // Beats minus one
  typedef logic [7:0]        ax_len_t;
  // log2 of bytes per beat
  typedef logic [2:0]        ax_size_t;

  // Element width, encoded as log2 of the byte count
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // One vector load or store from the sequencer
  typedef struct packed {
    addr_t   addr;
    vlen_t   vl;
    stride_t stride;
    vew_e    vew;
    logic    is_load;
    logic    is_burst;   // unit stride, issued as one INCR burst
  } vmem_req_t;

  // AR/AW payload, burst type is always INCR
  typedef struct packed {
    addr_t    addr;
    ax_len_t  len;
    ax_size_t size;
  } ax_req_t;

  // Copy of an issued request for the load/store units
  typedef struct packed {
    addr_t    addr;
    ax_len_t  len;
    ax_size_t size;
    logic     is_load;
  } lsu_req_t;

  // Control FSM
  typedef enum logic [1:0] {
    IDLE,
    CHECK,
    WAITING,
    REQUESTING
  } ctrl_state_e;

endpackage

`default_nettype wire

//--- addrgen_top.sv
// Vector memory address generator, top level
// Turns vector load/store requests into AR/AW requests and queues
// a copy of each one for the load/store units

`timescale 1ns/1ps
`default_nettype none

module addrgen_top (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  // Sequencer side
  input  wire addrgen_pkg::vmem_req_t req_i,
  input  wire logic                   req_valid_i,
  output logic                        ack_o,
  output logic                        exc_o,
  input  wire logic                   core_st_pending_i,
  // AR channel
  output addrgen_pkg::ax_req_t        ar_o,
  output logic                        ar_valid_o,
  input  wire logic                   ar_ready_i,
  // AW channel
  output addrgen_pkg::ax_req_t        aw_o,
  output logic                        aw_valid_o,
  input  wire logic                   aw_ready_i,
  // Load/store unit queue
  output addrgen_pkg::lsu_req_t       lsu_req_o,
  output logic                        lsu_req_valid_o,
  input  wire logic                   lsu_req_ready_i
);

  import addrgen_pkg::*;

  logic     load;
  logic     step;
  logic     issue;
  logic     issue_ok;
  logic     ax_done;
  logic     is_load;
  logic     last;
  addr_t    cur_addr;
  ax_size_t beat_size;
  ax_len_t  beat_len;
  lsu_req_t q_data;
  logic     q_empty;
  logic     q_full;

  //////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////

  addrgen_ctrl u_ctrl (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .req_i             (req_i),
    .req_valid_i       (req_valid_i),
    .core_st_pending_i (core_st_pending_i),
    .last_i            (last),
    .issue_ok_i        (issue_ok),
    .ax_done_i         (ax_done),
    .load_o            (load),
    .step_o            (step),
    .issue_o           (issue),
    .is_load_o         (is_load),
    .is_burst_o        (),
    .vew_o             (),
    .ack_o             (ack_o),
    .exc_o             (exc_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////////////////////////

  beat_width_select u_beat (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .load_i (load),
    .req_i  (req_i),
    .size_o (beat_size),
    .len_o  (beat_len)
  );

  stride_walker u_walker (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .load_i (load),
    .step_i (step),
    .req_i  (req_i),
    .addr_o (cur_addr),
    .last_o (last)
  );

  // Head direction comes straight from the queue output
  ax_formatter u_fmt (
    .issue_i          (issue),
    .is_load_i        (is_load),
    .addr_i           (cur_addr),
    .size_i           (beat_size),
    .len_i            (beat_len),
    .ar_ready_i       (ar_ready_i),
    .aw_ready_i       (aw_ready_i),
    .q_head_is_load_i (lsu_req_o.is_load),
    .q_empty_i        (q_empty),
    .q_full_i         (q_full),
    .ar_o             (ar_o),
    .ar_valid_o       (ar_valid_o),
    .aw_o             (aw_o),
    .aw_valid_o       (aw_valid_o),
    .issue_ok_o       (issue_ok),
    .ax_done_o        (ax_done),
    .q_data_o         (q_data)
  );

  lsu_req_queue u_queue (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .push_i          (ax_done),
    .data_i          (q_data),
    .lsu_req_ready_i (lsu_req_ready_i),
    .lsu_req_o       (lsu_req_o),
    .lsu_req_valid_o (lsu_req_valid_o),
    .empty_o         (q_empty),
    .full_o          (q_full)
  );

endmodule

`default_nettype wire

//--- ax_formatter.sv
// AR/AW request formatter
// Builds channel and queue payloads, enforces load/store ordering
// through the queue head and steers valid and ready by direction

`timescale 1ns/1ps
`default_nettype none

module ax_formatter (
  input  wire logic                  issue_i,
  input  wire logic                  is_load_i,
  input  wire addrgen_pkg::addr_t    addr_i,
  input  wire addrgen_pkg::ax_size_t size_i,
  input  wire addrgen_pkg::ax_len_t  len_i,
  input  wire logic                  ar_ready_i,
  input  wire logic                  aw_ready_i,
  // Queue status
  input  wire logic                  q_head_is_load_i,
  input  wire logic                  q_empty_i,
  input  wire logic                  q_full_i,
  output addrgen_pkg::ax_req_t       ar_o,
  output logic                       ar_valid_o,
  output addrgen_pkg::ax_req_t       aw_o,
  output logic                       aw_valid_o,
  output logic                       issue_ok_o,
  output logic                       ax_done_o,
  output addrgen_pkg::lsu_req_t      q_data_o
);

  import addrgen_pkg::*;

  logic   order_ok;
  ax_req_t ax_req;

  // No switch of channel while the other direction is still queued
  assign order_ok = (q_empty_i || (q_head_is_load_i == is_load_i)) && !q_full_i;

  assign issue_ok_o = issue_i && order_ok;

  // Same payload on both channels, valid picks one
  assign ax_req = '{addr: addr_i, len: len_i, size: size_i};
  assign ar_o   = ax_req;
  assign aw_o   = ax_req;

  assign ar_valid_o = issue_ok_o && is_load_i;
  assign aw_valid_o = issue_ok_o && !is_load_i;

  // Handshake done, also the queue push
  assign ax_done_o = (ar_valid_o && ar_ready_i) || (aw_valid_o && aw_ready_i);

  assign q_data_o = '{addr: addr_i, len: len_i, size: size_i, is_load: is_load_i};

endmodule

`default_nettype wire

//--- beat_width_select.sv
// Beat size and burst length selection
// Narrows the beat for misaligned unit-stride stores and sizes the burst

`timescale 1ns/1ps
`default_nettype none

module beat_width_select (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire logic                   load_i,
  input  wire addrgen_pkg::vmem_req_t req_i,
  output addrgen_pkg::ax_size_t       size_o,
  output addrgen_pkg::ax_len_t        len_o
);

  import addrgen_pkg::*;

  // Trailing zero count of a nonzero bus offset
  function automatic ax_size_t trailing_zeros(input logic [BUS_SIZE-1:0] value);
    ax_size_t cnt;
    cnt = ax_size_t'(BUS_SIZE);
    // Scan from the top so the lowest set bit wins
    for (int i = BUS_SIZE - 1; i >= 0; i--) begin
      if (value[i]) begin
        cnt = ax_size_t'(i);
      end
    end
    return cnt;
  endfunction

  logic [BUS_SIZE-1:0]      bus_offset;
  logic [VL_W+BUS_SIZE-1:0] total_bytes;
  ax_size_t                 size_d, size_q;
  ax_len_t                  len_d, len_q;

  assign bus_offset  = req_i.addr[BUS_SIZE-1:0];
  assign total_bytes = {{BUS_SIZE{1'b0}}, req_i.vl} << req_i.vew;

  always_comb begin
    if (!req_i.is_burst) begin
      // Strided, one element per beat
      size_d = ax_size_t'(req_i.vew);
      len_d  = '0;
    end else begin
      // Store unit can't realign, so shrink the beat to the start offset
      if (!req_i.is_load && (bus_offset != '0)) begin
        size_d = trailing_zeros(bus_offset);
      end else begin
        size_d = ax_size_t'(BUS_SIZE);
      end
      len_d = ax_len_t'((total_bytes - 1'b1) >> size_d);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      size_q <= '0;
      len_q  <= '0;
    end else if (load_i) begin
      size_q <= size_d;
      len_q  <= len_d;
    end
  end

  assign size_o = size_q;
  assign len_o  = len_q;

endmodule

`default_nettype wire

//--- lsu_req_queue.sv
// Load/store unit request queue
// Small FIFO of issued AX requests, popped by the load/store units

`timescale 1ns/1ps
`default_nettype none

module lsu_req_queue (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire logic                  push_i,
  input  wire addrgen_pkg::lsu_req_t data_i,
  input  wire logic                  lsu_req_ready_i,
  output addrgen_pkg::lsu_req_t      lsu_req_o,
  output logic                       lsu_req_valid_o,
  output logic                       empty_o,
  output logic                       full_o
);

  import addrgen_pkg::*;

  lsu_req_t mem_q [QUEUE_DEPTH];

  logic [QUEUE_PTR_W-1:0] wr_ptr_q;
  logic [QUEUE_PTR_W-1:0] rd_ptr_q;
  logic [QUEUE_CNT_W-1:0] count_q;

  logic push;
  logic pop;

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == QUEUE_CNT_W'(QUEUE_DEPTH));

  // Drop pushes into a full queue
  assign push = push_i && !full_o;
  assign pop  = lsu_req_valid_o && lsu_req_ready_i;

  //////////////////////////////////////////////////////////////////////
  // Pointers and fill level
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop keeps the level
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  assign lsu_req_o       = mem_q[rd_ptr_q];
  assign lsu_req_valid_o = !empty_o;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Compile and run the address generator testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tb_addrgen \
  -o tb_addrgen && ./obj_dir/tb_addrgen > sim.log 2>&1 || echo "Simulation build or run failed"
[ -f sim.log ] && cat sim.log
grep -qx "NO ERRORS" sim.log && echo "PASS" && exit 0 || echo "FAIL"
exit 1

//--- stride_walker.sv
// Element address walker
// Tracks the current element address and the elements still to issue

`timescale 1ns/1ps
`default_nettype none

module stride_walker (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  // Capture base and vl
  input  wire logic                   load_i,
  // One AX transfer done, advance
  input  wire logic                   step_i,
  input  wire addrgen_pkg::vmem_req_t req_i,
  output addrgen_pkg::addr_t          addr_o,
  output logic                        last_o
);

  import addrgen_pkg::*;

  addr_t   addr_q;
  vlen_t   cnt_q;
  stride_t stride_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q   <= '0;
      cnt_q    <= '0;
      stride_q <= '0;
    end else if (load_i) begin
      addr_q   <= req_i.addr;
      cnt_q    <= req_i.vl;
      stride_q <= req_i.stride;
    end else if (step_i) begin
      // Next element, the stride is a byte offset
      addr_q <= addr_q + addr_t'(stride_q);
      cnt_q  <= cnt_q - vlen_t'(1);
    end
  end

  assign addr_o = addr_q;
  // Only one element left to request
  assign last_o = (cnt_q == vlen_t'(1));

endmodule

`default_nettype wire

//--- tb_addrgen.sv
// Testbench for the vector memory address generator
// Reference model of AX requests and queue entries, random ready stalls,
// checks on ordering, back-pressure, exceptions and completion

`timescale 1ns/1ps
`default_nettype none

module tb_addrgen;

  import addrgen_pkg::*;

  logic      clk_i;
  logic      rst_ni;
  vmem_req_t req_i;
  logic      req_valid_i;
  logic      ack_o;
  logic      exc_o;
  logic      core_st_pending_i;
  ax_req_t   ar_o;
  logic      ar_valid_o;
  logic      ar_ready_i;
  ax_req_t   aw_o;
  logic      aw_valid_o;
  logic      aw_ready_i;
  lsu_req_t  lsu_req_o;
  logic      lsu_req_valid_o;
  logic      lsu_req_ready_i;

  // Expected AX transfers in issue order, then their queue copies
  lsu_req_t exp_ax[$];
  lsu_req_t exp_lsu[$];

  integer      seed = 75483;
  int unsigned cycles = 0;
  int unsigned total_xfers = 0;
  int unsigned ack_cnt = 0;
  int unsigned acks_expected = 0;
  logic        exp_exc = 1'b0;
  logic        stall_en = 1'b0;
  logic        lsu_hold = 1'b0;
  logic        ar_held = 1'b0;
  logic        aw_held = 1'b0;

  addrgen_top u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Failure handling
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic show_mismatch(input string name, input logic [63:0] exp_v,
                               input logic [63:0] got_v);
    $display("** Error: %s expected 0x%h, got 0x%h", name, exp_v, got_v);
    abort_run();
  endtask

  task automatic stop_with(input string text);
    $display("Failure: %s", text);
    abort_run();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model and request driver
  //////////////////////////////////////////////////////////////////////

  task automatic expect_req(input vmem_req_t r);
    logic [31:0] ew_bytes;
    logic [2:0]  offset;
    int unsigned size;
    lsu_req_t    e;
    ew_bytes = 32'd1 << r.vew;
    // Base must sit on an element boundary
    exp_exc  = (r.addr % ew_bytes) != 0;
    e.is_load = r.is_load;
    if (!exp_exc && r.is_burst) begin
      offset = r.addr[2:0];
      size   = BUS_SIZE;
      // Store beats shrink to the largest power of two dividing the offset
      if (!r.is_load && offset != 3'd0) begin
        size = 0;
        while (offset[size] == 1'b0) begin
          size++;
        end
      end
      e.addr = r.addr;
      e.size = ax_size_t'(size);
      e.len  = ax_len_t'(((r.vl * ew_bytes) - 1) >> size);
      exp_ax.push_back(e);
      total_xfers++;
    end else if (!exp_exc) begin
      // One element per transfer
      for (int unsigned k = 0; k < r.vl; k++) begin
        e.addr = r.addr + k * r.stride;
        e.size = ax_size_t'(r.vew);
        e.len  = '0;
        exp_ax.push_back(e);
        total_xfers++;
      end
    end
  endtask

  task automatic send_req(input addr_t addr, input int unsigned vl, input stride_t stride,
                          input vew_e vew, input logic is_load, input logic is_burst);
    vmem_req_t r;
    r.addr     = addr;
    r.vl       = vlen_t'(vl);
    r.stride   = stride;
    r.vew      = vew;
    r.is_load  = is_load;
    r.is_burst = is_burst;
    expect_req(r);
    acks_expected++;
    @(negedge clk_i);
    req_i       = r;
    req_valid_i = 1'b1;
  endtask

  // Source holds the request until the ack
  task automatic wait_ack();
    while (ack_cnt < acks_expected) begin
      @(negedge clk_i);
    end
    req_valid_i = 1'b0;
  endtask

  task automatic run_req(input addr_t addr, input int unsigned vl, input stride_t stride,
                         input vew_e vew, input logic is_load, input logic is_burst);
    send_req(addr, vl, stride, vew, is_load, is_burst);
    wait_ack();
  endtask

  task automatic idle_cycles(input int unsigned n);
    repeat (n) @(negedge clk_i);
  endtask

  // Ready inputs change on the falling edge only
  always @(negedge clk_i) begin
    ar_ready_i      = stall_en ? (($random(seed) & 3) != 0) : 1'b1;
    aw_ready_i      = stall_en ? (($random(seed) & 3) != 0) : 1'b1;
    lsu_req_ready_i = !lsu_hold && (stall_en ? (($random(seed) & 3) != 0) : 1'b1);
  end

  //////////////////////////////////////////////////////////////////////
  // Monitor
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin : monitor
    ax_req_t act;
    ax_req_t exp_act;
    if (rst_ni) begin
      assert (!exc_o || ack_o) else stop_with("exc_o pulsed without ack_o");
      assert (!(ar_valid_o && aw_valid_o)) else stop_with("AR and AW valid raised together");
      assert (!(core_st_pending_i && (ar_valid_o || aw_valid_o)))
        else stop_with("AX valid raised while a scalar store is pending");
      assert (!((ar_valid_o || aw_valid_o) && exp_lsu.size() == QUEUE_DEPTH))
        else stop_with("AX valid raised while the queue is full");
      assert (!(ar_valid_o && lsu_req_valid_o && !lsu_req_o.is_load))
        else stop_with("AR valid raised with a store at the queue head");
      assert (!(aw_valid_o && lsu_req_valid_o && lsu_req_o.is_load))
        else stop_with("AW valid raised with a load at the queue head");
      assert (!(ar_held && !ar_valid_o)) else stop_with("ar_valid_o dropped before its transfer");
      assert (!(aw_held && !aw_valid_o)) else stop_with("aw_valid_o dropped before its transfer");
      // Head is compared before this cycle's push
      if (lsu_req_valid_o && lsu_req_ready_i) begin
        if (exp_lsu.size() == 0) begin
          stop_with("queue popped with no entry expected");
        end else begin
          assert (lsu_req_o == exp_lsu[0]) else show_mismatch("lsu_req_o", exp_lsu[0], lsu_req_o);
          void'(exp_lsu.pop_front());
        end
      end
      if (ar_valid_o || aw_valid_o) begin
        act = ar_valid_o ? ar_o : aw_o;
        if (exp_ax.size() == 0) begin
          stop_with("AX valid raised with no transfer expected");
        end else begin
          exp_act = '{addr: exp_ax[0].addr, len: exp_ax[0].len, size: exp_ax[0].size};
          assert (ar_valid_o == exp_ax[0].is_load)
            else show_mismatch("ar_valid_o", exp_ax[0].is_load, ar_valid_o);
          assert (act == exp_act) else show_mismatch(ar_valid_o ? "ar_o" : "aw_o", exp_act, act);
          if ((ar_valid_o && ar_ready_i) || (aw_valid_o && aw_ready_i)) begin
            exp_lsu.push_back(exp_ax.pop_front());
          end
        end
      end
      if (ack_o) begin
        ack_cnt++;
        assert (exc_o == exp_exc) else show_mismatch("exc_o", exp_exc, exc_o);
        assert (exp_ax.size() == 0) else stop_with("ack_o pulsed before all transfers were issued");
      end
      ar_held = ar_valid_o && !ar_ready_i;
      aw_held = aw_valid_o && !aw_ready_i;
    end
  end

  // Limit grows with the transfers handed to the model
  always @(posedge clk_i) begin
    cycles++;
    if (cycles > 20 * total_xfers + 500) begin
      $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
      abort_run();
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst_ni            = 1'b0;
    req_i             = '0;
    req_valid_i       = 1'b0;
    core_st_pending_i = 1'b0;
    ar_ready_i        = 1'b1;
    aw_ready_i        = 1'b1;
    lsu_req_ready_i   = 1'b1;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // Unit-stride load, then misaligned and aligned unit-stride stores
    run_req(32'h0000_1000, 16, 32'd0, EW32, 1'b1, 1'b1);
    run_req(32'h0000_2006, 10, 32'd0, EW16, 1'b0, 1'b1);
    run_req(32'h0000_3004, 5, 32'd0, EW32, 1'b0, 1'b1);
    run_req(32'h0000_3800, 3, 32'd0, EW64, 1'b0, 1'b1);

    // Strided accesses under random ready stalls, one negative stride
    stall_en <= 1'b1;
    run_req(32'h0000_4000, 6, 32'd24, EW64, 1'b1, 1'b0);
    run_req(32'h0000_5002, 5, 32'd6, EW16, 1'b0, 1'b0);
    run_req(32'h0000_6040, 4, 32'hFFFF_FFF0, EW32, 1'b0, 1'b0);
    for (int i = 0; i < 8; i++) begin
      run_req(addr_t'($random(seed) & 32'h0000_FFFF), ($random(seed) & 63) + 1,
              stride_t'($random(seed) & 32'hFF), vew_e'($random(seed) & 3),
              1'($random(seed)), 1'($random(seed)));
    end

    // Bases off the element boundary
    run_req(32'h0000_7003, 4, 32'd0, EW32, 1'b1, 1'b1);
    run_req(32'h0000_7004, 3, 32'd8, EW64, 1'b0, 1'b0);

    // Pending scalar store holds the request
    stall_en <= 1'b0;
    @(negedge clk_i);
    core_st_pending_i = 1'b1;
    send_req(32'h0000_8000, 8, 32'd0, EW64, 1'b1, 1'b1);
    idle_cycles(8);
    assert (exp_ax.size() == 1) else stop_with("request issued during a pending scalar store");
    core_st_pending_i = 1'b0;
    wait_ack();

    // Full queue stops issuing
    lsu_hold <= 1'b1;
    send_req(32'h0000_9000, 6, 32'd8, EW64, 1'b1, 1'b0);
    idle_cycles(20);
    assert (exp_lsu.size() == QUEUE_DEPTH)
      else show_mismatch("queue fill", QUEUE_DEPTH, exp_lsu.size());
    lsu_hold <= 1'b0;
    wait_ack();

    // Store waits behind a queued load
    idle_cycles(10);
    lsu_hold <= 1'b1;
    run_req(32'h0000_A000, 8, 32'd0, EW64, 1'b1, 1'b1);
    send_req(32'h0000_B000, 4, 32'd0, EW64, 1'b0, 1'b1);
    idle_cycles(10);
    assert (exp_ax.size() == 1) else stop_with("store issued behind a queued load");
    lsu_hold <= 1'b0;
    wait_ack();

    // Let the queue drain
    while (exp_lsu.size() != 0) begin
      @(negedge clk_i);
    end
    idle_cycles(4);
    if (exp_ax.size() == 0 && exp_lsu.size() == 0 && ack_cnt == acks_expected) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      $display("Failure: requests left over at the end of the run");
      abort_run();
    end
  end

endmodule

`default_nettype wire

//--- verilog.f
addrgen_pkg.sv
addrgen_ctrl.sv
beat_width_select.sv
stride_walker.sv
ax_formatter.sv
lsu_req_queue.sv
addrgen_top.sv
tb_addrgen.sv
